/* design/backing_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module backing_ram import cache_pkg::*; (
   input  wire logic         clk_i,
   input  wire logic         rst_i,
   input  wire logic         be_req_i,
   input  wire be_req_t      be_req_data_i,
   output logic [DATA_W-1:0] be_rdata_o,
   output logic              be_ack_o
);

   localparam int NWORDS = 2 ** ADDR_W;

   logic [DATA_W-1:0] mem_q [NWORDS];

   initial begin
      for (int i = 0; i < NWORDS; i++) begin
         mem_q[i] = '0;
      end
   end

   // Read returns the word as it was before this beat's write
   always_ff @(posedge clk_i) begin
      if (be_req_i) begin
         be_rdata_o <= mem_q[be_req_data_i.addr];
         for (int b = 0; b < NBYTES; b++) begin
            if (be_req_data_i.wstrb[b]) begin
               mem_q[be_req_data_i.addr][b*8 +: 8] <= be_req_data_i.wdata[b*8 +: 8];
            end
         end
      end
   end

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         be_ack_o <= 1'b0;
      end else begin
         be_ack_o <= be_req_i;
      end
   end

endmodule

`default_nettype wire

/* design/be_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module be_arbiter import cache_pkg::*; (
   input  wire logic    clk_i,
   input  wire logic    rst_i,
   input  wire logic    wtb_req_i,
   input  wire be_req_t wtb_data_i,
   output logic         wtb_ack_o,
   input  wire logic    fill_req_i,
   input  wire be_req_t fill_data_i,
   output logic         fill_ack_o,
   output logic         be_req_o,
   output be_req_t      be_req_data_o,
   input  wire logic    be_ack_i
);

   logic in_flight_q;
   logic grant_wtb_q;
   logic grant_wtb;

   // Buffer first so older writes reach memory before a refill
   assign grant_wtb = in_flight_q ? grant_wtb_q : wtb_req_i;

   assign be_req_o      = !in_flight_q && (wtb_req_i || fill_req_i);
   assign be_req_data_o = grant_wtb ? wtb_data_i : fill_data_i;

   assign wtb_ack_o  = be_ack_i && grant_wtb_q;
   assign fill_ack_o = be_ack_i && !grant_wtb_q;

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         in_flight_q <= 1'b0;
         grant_wtb_q <= 1'b0;
      end else begin
         if (be_ack_i) begin
            in_flight_q <= 1'b0;
         end else if (be_req_o) begin
            in_flight_q <= 1'b1;
         end
         if (be_req_o) begin
            grant_wtb_q <= grant_wtb;
         end
      end
   end

endmodule

`default_nettype wire

/* design/cache_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl import cache_pkg::*; (
   input  wire logic              clk_i,
   input  wire logic              rst_i,
   // Front end
   input  wire logic              req_i,
   input  wire fe_req_t           req_data_i,
   output logic [DATA_W-1:0]      rdata_o,
   output logic                   ack_o,
   // Store
   output cache_addr_u            lookup_addr_o,
   input  wire logic              hit_i,
   input  wire logic [DATA_W-1:0] store_rdata_i,
   output logic                   word_we_o,
   output logic [DATA_W-1:0]      word_wdata_o,
   output logic [NBYTES-1:0]      word_wstrb_o,
   // Write-through buffer
   output logic                   wtb_push_o,
   output be_req_t                wtb_entry_o,
   input  wire logic              wtb_full_i,
   // Line fill
   output logic                   fill_start_o,
   output cache_addr_u            fill_line_o,
   input  wire logic              fill_done_i
);

   typedef enum logic [2:0] {
      S_IDLE,
      S_LOOKUP,
      S_WPUSH,
      S_REFILL,
      S_RESPOND
   } state_t;

   state_t  state_q;
   state_t  state_d;
   fe_req_t req_q;
   logic    is_write;
   logic    can_push;

   assign is_write = |req_q.wstrb;
   assign can_push = is_write && !wtb_full_i &&
                     ((state_q == S_LOOKUP) || (state_q == S_WPUSH));

   // Incoming address feeds the store so the lookup is ready next cycle
   assign lookup_addr_o = (state_q == S_IDLE) ? req_data_i.addr : req_q.addr;

   assign word_we_o    = (state_q == S_LOOKUP) && is_write && hit_i;
   assign word_wdata_o = req_q.wdata;
   assign word_wstrb_o = req_q.wstrb;

   assign wtb_push_o  = can_push;
   assign wtb_entry_o = '{addr: req_q.addr.raw, wdata: req_q.wdata, wstrb: req_q.wstrb};

   assign fill_start_o = (state_q == S_LOOKUP) && !is_write && !hit_i;
   assign fill_line_o  = req_q.addr;

   assign ack_o = state_q == S_RESPOND;

   always_comb begin
      state_d = state_q;
      case (state_q)
         S_IDLE: begin
            if (req_i) begin
               state_d = S_LOOKUP;
            end
         end
         S_LOOKUP: begin
            if (!is_write) begin
               state_d = hit_i ? S_RESPOND : S_REFILL;
            end else begin
               state_d = can_push ? S_RESPOND : S_WPUSH;
            end
         end
         S_WPUSH: begin
            if (can_push) begin
               state_d = S_RESPOND;
            end
         end
         // Look up again once the line is in, which then hits
         S_REFILL: begin
            if (fill_done_i) begin
               state_d = S_LOOKUP;
            end
         end
         default: begin
            state_d = S_IDLE;
         end
      endcase
   end

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         state_q <= S_IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   always_ff @(posedge clk_i) begin
      if ((state_q == S_IDLE) && req_i) begin
         req_q <= req_data_i;
      end
      if (state_q == S_LOOKUP) begin
         rdata_o <= store_rdata_i;
      end
   end

endmodule

`default_nettype wire

/* design/cache_pkg.sv */
`default_nettype none

package cache_pkg;

   localparam int ADDR_W     = 10;
   localparam int DATA_W     = 32;
   localparam int NBYTES     = DATA_W / 8;
   localparam int TAG_W      = 4;
   localparam int INDEX_W    = 4;
   localparam int OFFSET_W   = 2;
   localparam int LINE_WORDS = 2 ** OFFSET_W;

   typedef struct packed {
      logic [TAG_W-1:0]    tag;
      logic [INDEX_W-1:0]  index;
      logic [OFFSET_W-1:0] offset;
   } cache_addr_s;

   // Word address goes raw to memory and split into fields for lookup
   typedef union packed {
      logic [ADDR_W-1:0] raw;
      cache_addr_s       f;
   } cache_addr_u;

   // A zero strobe marks a read
   typedef struct packed {
      cache_addr_u       addr;
      logic [DATA_W-1:0] wdata;
      logic [NBYTES-1:0] wstrb;
   } fe_req_t;

   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] wdata;
      logic [NBYTES-1:0] wstrb;
   } be_req_t;

endpackage

`default_nettype wire

/* design/cache_store.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_store import cache_pkg::*; (
   input  wire logic              clk_i,
   input  wire logic              rst_i,
   // Lookup and word write share this address
   input  wire cache_addr_u       lookup_addr_i,
   output logic                   hit_o,
   output logic [DATA_W-1:0]      rdata_o,
   input  wire logic              word_we_i,
   input  wire logic [DATA_W-1:0] word_wdata_i,
   input  wire logic [NBYTES-1:0] word_wstrb_i,
   input  wire logic              fill_we_i,
   input  wire cache_addr_u       fill_addr_i,
   input  wire logic [DATA_W-1:0] fill_data_i
);

   localparam int NLINES = 2 ** INDEX_W;
   localparam int NWORDS = NLINES * LINE_WORDS;

   logic [TAG_W-1:0]  tag_q   [NLINES];
   logic [NLINES-1:0] valid_q;
   logic [DATA_W-1:0] data_q  [NWORDS];

   logic [INDEX_W+OFFSET_W-1:0] lookup_word;
   logic [INDEX_W+OFFSET_W-1:0] fill_word;
   logic                        fill_first;
   logic                        fill_last;

   assign lookup_word = {lookup_addr_i.f.index, lookup_addr_i.f.offset};
   assign fill_word   = {fill_addr_i.f.index, fill_addr_i.f.offset};
   assign fill_first  = fill_addr_i.f.offset == '0;
   assign fill_last   = fill_addr_i.f.offset == OFFSET_W'(LINE_WORDS - 1);

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         valid_q <= '0;
         hit_o   <= 1'b0;
      end else begin
         hit_o <= valid_q[lookup_addr_i.f.index] &&
                  (tag_q[lookup_addr_i.f.index] == lookup_addr_i.f.tag);
         // Line is unusable while it is partly refilled
         if (fill_we_i && fill_first) begin
            valid_q[fill_addr_i.f.index] <= 1'b0;
         end
         if (fill_we_i && fill_last) begin
            valid_q[fill_addr_i.f.index] <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      rdata_o <= data_q[lookup_word];
      if (fill_we_i) begin
         data_q[fill_word] <= fill_data_i;
         if (fill_last) begin
            tag_q[fill_addr_i.f.index] <= fill_addr_i.f.tag;
         end
      end
      if (word_we_i) begin
         for (int b = 0; b < NBYTES; b++) begin
            if (word_wstrb_i[b]) begin
               data_q[lookup_word][b*8 +: 8] <= word_wdata_i[b*8 +: 8];
            end
         end
      end
   end

endmodule

`default_nettype wire

/* design/cache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_top import cache_pkg::*; #(
   parameter int WTBUF_DEPTH_W = 2
) (
   input  wire logic         clk_i,
   input  wire logic         rst_i,
   input  wire logic         req_i,
   input  wire fe_req_t      req_data_i,
   output logic [DATA_W-1:0] rdata_o,
   output logic              ack_o,
   output logic              wtb_empty_o
);

   // Controller to store
   wire cache_addr_u       lookup_addr;
   wire logic              hit;
   wire logic [DATA_W-1:0] store_rdata;
   wire logic              word_we;
   wire logic [DATA_W-1:0] word_wdata;
   wire logic [NBYTES-1:0] word_wstrb;

   // Controller to buffer and fill engine
   wire logic              wtb_push;
   wire be_req_t           wtb_entry;
   wire logic              wtb_full;
   wire logic              fill_start;
   wire cache_addr_u       fill_line;
   wire logic              fill_done;
   wire logic              fill_we;
   wire cache_addr_u       fill_addr;
   wire logic [DATA_W-1:0] fill_data;

   // Back end
   wire logic              wtb_req;
   wire be_req_t           wtb_req_data;
   wire logic              wtb_ack;
   wire logic              fill_req;
   wire be_req_t           fill_req_data;
   wire logic              fill_ack;
   wire logic              be_req;
   wire be_req_t           be_req_data;
   wire logic              be_ack;
   wire logic [DATA_W-1:0] be_rdata;

   cache_ctrl ctrl_i (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .req_i         (req_i),
      .req_data_i    (req_data_i),
      .rdata_o       (rdata_o),
      .ack_o         (ack_o),
      .lookup_addr_o (lookup_addr),
      .hit_i         (hit),
      .store_rdata_i (store_rdata),
      .word_we_o     (word_we),
      .word_wdata_o  (word_wdata),
      .word_wstrb_o  (word_wstrb),
      .wtb_push_o    (wtb_push),
      .wtb_entry_o   (wtb_entry),
      .wtb_full_i    (wtb_full),
      .fill_start_o  (fill_start),
      .fill_line_o   (fill_line),
      .fill_done_i   (fill_done)
   );

   cache_store store_i (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .lookup_addr_i (lookup_addr),
      .hit_o         (hit),
      .rdata_o       (store_rdata),
      .word_we_i     (word_we),
      .word_wdata_i  (word_wdata),
      .word_wstrb_i  (word_wstrb),
      .fill_we_i     (fill_we),
      .fill_addr_i   (fill_addr),
      .fill_data_i   (fill_data)
   );

   write_through_buffer #(
      .WTBUF_DEPTH_W (WTBUF_DEPTH_W)
   ) wtb_i (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .push_i        (wtb_push),
      .entry_i       (wtb_entry),
      .full_o        (wtb_full),
      .empty_o       (wtb_empty_o),
      .be_req_o      (wtb_req),
      .be_req_data_o (wtb_req_data),
      .be_ack_i      (wtb_ack)
   );

   line_fill fill_i (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .start_i       (fill_start),
      .line_i        (fill_line),
      .done_o        (fill_done),
      .fill_we_o     (fill_we),
      .fill_addr_o   (fill_addr),
      .fill_data_o   (fill_data),
      .be_req_o      (fill_req),
      .be_req_data_o (fill_req_data),
      .be_ack_i      (fill_ack),
      .be_rdata_i    (be_rdata)
   );

   be_arbiter arb_i (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .wtb_req_i     (wtb_req),
      .wtb_data_i    (wtb_req_data),
      .wtb_ack_o     (wtb_ack),
      .fill_req_i    (fill_req),
      .fill_data_i   (fill_req_data),
      .fill_ack_o    (fill_ack),
      .be_req_o      (be_req),
      .be_req_data_o (be_req_data),
      .be_ack_i      (be_ack)
   );

   backing_ram ram_i (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .be_req_i      (be_req),
      .be_req_data_i (be_req_data),
      .be_rdata_o    (be_rdata),
      .be_ack_o      (be_ack)
   );

endmodule

`default_nettype wire

/* design/line_fill.sv */
`timescale 1ns/1ps
`default_nettype none

module line_fill import cache_pkg::*; (
   input  wire logic              clk_i,
   input  wire logic              rst_i,
   input  wire logic              start_i,
   input  wire cache_addr_u       line_i,
   output logic                   done_o,
   output logic                   fill_we_o,
   output cache_addr_u            fill_addr_o,
   output logic [DATA_W-1:0]      fill_data_o,
   output logic                   be_req_o,
   output be_req_t                be_req_data_o,
   input  wire logic              be_ack_i,
   input  wire logic [DATA_W-1:0] be_rdata_i
);

   logic                busy_q;
   logic [OFFSET_W-1:0] beat_q;
   cache_addr_u         line_q;
   cache_addr_u         beat_addr;

   assign beat_addr.raw = {line_q.f.tag, line_q.f.index, beat_q};

   // Reads only, so strobes stay zero
   assign be_req_o      = busy_q && !be_ack_i;
   assign be_req_data_o = '{addr: beat_addr.raw, wdata: '0, wstrb: '0};

   assign fill_we_o   = busy_q && be_ack_i;
   assign fill_addr_o = beat_addr;
   assign fill_data_o = be_rdata_i;

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         busy_q <= 1'b0;
         beat_q <= '0;
         done_o <= 1'b0;
      end else begin
         done_o <= 1'b0;
         if (start_i && !busy_q) begin
            busy_q <= 1'b1;
            beat_q <= '0;
         end else if (fill_we_o) begin
            beat_q <= beat_q + 1'b1;
            if (beat_q == OFFSET_W'(LINE_WORDS - 1)) begin
               busy_q <= 1'b0;
               done_o <= 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (start_i && !busy_q) begin
         line_q <= line_i;
      end
   end

endmodule

`default_nettype wire

/* design/write_through_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module write_through_buffer import cache_pkg::*; #(
   parameter int WTBUF_DEPTH_W = 2
) (
   input  wire logic    clk_i,
   input  wire logic    rst_i,
   input  wire logic    push_i,
   input  wire be_req_t entry_i,
   output logic         full_o,
   output logic         empty_o,
   output logic         be_req_o,
   output be_req_t      be_req_data_o,
   input  wire logic    be_ack_i
);

   localparam int DEPTH = 2 ** WTBUF_DEPTH_W;

   be_req_t                mem_q [DEPTH];
   logic [WTBUF_DEPTH_W-1:0] wr_ptr_q;
   logic [WTBUF_DEPTH_W-1:0] rd_ptr_q;
   logic [WTBUF_DEPTH_W:0]   count_q;
   logic                     pop;

   // Head stays stored until memory acks it
   assign pop     = be_ack_i;
   assign empty_o = count_q == '0;
   assign full_o  = count_q == (WTBUF_DEPTH_W + 1)'(DEPTH);

   assign be_req_o      = !empty_o && !be_ack_i;
   assign be_req_data_o = mem_q[rd_ptr_q];

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (push_i) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (pop) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         if (push_i && !pop) begin
            count_q <= count_q + 1'b1;
         end else if (pop && !push_i) begin
            count_q <= count_q - 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (push_i) begin
         mem_q[wr_ptr_q] <= entry_i;
      end
   end

endmodule

`default_nettype wire

/* testbench/cache_tb_tasks.svh */
`ifndef CACHE_TB_TASKS_SVH
`define CACHE_TB_TASKS_SVH

localparam int TIMEOUT_CYCLES = 200;

task automatic fail_run(input string why);
   $display("%s", why);
   $display("TEST FAIL");
   $fatal(1);
endtask

task automatic check_data(input string name, input logic [DATA_W-1:0] exp,
                          input logic [DATA_W-1:0] act);
   if (act !== exp) begin
      fail_run($sformatf("ERR %0t %s expected %h actual %h", $time, name, exp, act));
   end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
   if (act !== exp) begin
      fail_run($sformatf("ERR %0t %s expected %b actual %b", $time, name, exp, act));
   end
endtask

task automatic check_cycles(input string name, input int exp, input int act);
   if (act != exp) begin
      fail_run($sformatf("ERR %0t %s expected %0d actual %0d", $time, name, exp, act));
   end
endtask

// Drives one front-end transfer and counts cycles from the drive edge to the ack
task automatic issue_request(input cache_addr_u addr, input logic [DATA_W-1:0] wdata,
                             input logic [NBYTES-1:0] wstrb,
                             output logic [DATA_W-1:0] data, output int cycles);
   fe_req_t word_req;
   logic    seen;
   word_req.addr  = addr;
   word_req.wdata = wdata;
   word_req.wstrb = wstrb;
   @(negedge clk);
   // Previous ack must be a single-cycle pulse
   check_bit("ack_o", 1'b0, ack);
   req      = 1'b1;
   req_data = word_req;
   cycles   = 0;
   seen     = 1'b0;
   while (!seen) begin
      @(negedge clk);
      cycles++;
      seen = ack;
      if (!seen && cycles >= TIMEOUT_CYCLES) begin
         fail_run($sformatf("Timeout: no ack_o for address %03h", addr.raw));
      end
   end
   data     = rdata;
   req      = 1'b0;
   req_data = '0;
endtask

task automatic wait_wtb_empty();
   int cycles;
   cycles = 0;
   while (!wtb_empty) begin
      @(negedge clk);
      cycles++;
      if (!wtb_empty && cycles >= TIMEOUT_CYCLES) begin
         fail_run("Timeout: write-through buffer never drained");
      end
   end
endtask

task automatic write_word(input cache_addr_u addr, input logic [DATA_W-1:0] wdata,
                          input logic [NBYTES-1:0] wstrb);
   logic [DATA_W-1:0] unused;
   int                cycles;
   issue_request(addr, wdata, wstrb, unused, cycles);
   ref_mem[addr.raw] = merge_bytes(ref_mem[addr.raw], wdata, wstrb);
endtask

task automatic read_check(input cache_addr_u addr, output int cycles);
   logic [DATA_W-1:0] data;
   issue_request(addr, '0, '0, data, cycles);
   check_data($sformatf("rdata_o[%03h]", addr.raw), ref_mem[addr.raw], data);
endtask

`endif

/* testbench/cache_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_tb import cache_pkg::*; ();

   logic              clk = 1'b0;
   logic              rst;
   logic              req;
   fe_req_t           req_data;
   logic [DATA_W-1:0] rdata;
   logic              ack;
   logic              wtb_empty;
   logic [DATA_W-1:0] ref_mem [2**ADDR_W];
   integer            seed;

   function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old,
                                                     input logic [DATA_W-1:0] data,
                                                     input logic [NBYTES-1:0] strb);
      logic [DATA_W-1:0] res;
      res = old;
      for (int b = 0; b < NBYTES; b++) begin
         if (strb[b]) begin
            res[b*8 +: 8] = data[b*8 +: 8];
         end
      end
      return res;
   endfunction

   function automatic cache_addr_u make_addr(input int tag, input int index, input int offset);
      cache_addr_u a;
      a.f.tag    = TAG_W'(tag);
      a.f.index  = INDEX_W'(index);
      a.f.offset = OFFSET_W'(offset);
      return a;
   endfunction

   `include "cache_tb_tasks.svh"

   always #5 clk = ~clk;

   cache_top #(
      .WTBUF_DEPTH_W (2)
   ) dut_i (
      .clk_i       (clk),
      .rst_i       (rst),
      .req_i       (req),
      .req_data_i  (req_data),
      .rdata_o     (rdata),
      .ack_o       (ack),
      .wtb_empty_o (wtb_empty)
   );

   task automatic test_reset();
      cache_addr_u a;
      int          cycles;
      check_bit("ack_o", 1'b0, ack);
      check_bit("wtb_empty_o", 1'b1, wtb_empty);
      a.raw = ADDR_W'($random(seed));
      read_check(a, cycles);
      read_check(make_addr(15, 15, 3), cycles);
   endtask

   // Write misses go to memory only, so each read refills behind the buffer
   task automatic test_write_read();
      cache_addr_u addrs [6];
      int          cycles;
      for (int i = 0; i < 6; i++) begin
         addrs[i].raw = ADDR_W'($random(seed));
         write_word(addrs[i], $random(seed), '1);
         read_check(addrs[i], cycles);
      end
      for (int i = 0; i < 6; i++) begin
         read_check(addrs[i], cycles);
      end
   endtask

   task automatic test_hit_reuse();
      int cycles;
      for (int w = 0; w < LINE_WORDS; w++) begin
         write_word(make_addr(3, 7, w), $random(seed), '1);
      end
      read_check(make_addr(3, 7, 0), cycles);
      for (int w = 0; w < LINE_WORDS; w++) begin
         read_check(make_addr(3, 7, w), cycles);
         check_cycles("read hit latency", 2, cycles);
      end
   endtask

   task automatic test_byte_strobes();
      cache_addr_u a;
      int          cycles;
      a = make_addr(2, 4, 1);
      write_word(a, $random(seed), '1);
      read_check(a, cycles);
      for (int s = 1; s < 16; s++) begin
         write_word(a, $random(seed), NBYTES'(s));
         read_check(a, cycles);
         check_cycles("resident read latency", 2, cycles);
      end
      // New tag each pass keeps the line out of the cache
      for (int s = 1; s < 16; s++) begin
         a = make_addr(s, 12, s % LINE_WORDS);
         write_word(a, $random(seed), '1);
         write_word(a, $random(seed), NBYTES'(s));
         read_check(a, cycles);
      end
   endtask

   task automatic test_backpressure();
      cache_addr_u addrs [12];
      int          cycles;
      for (int i = 0; i < 12; i++) begin
         addrs[i].raw = ADDR_W'(i * 83 + 5);
         write_word(addrs[i], $random(seed), '1);
      end
      wait_wtb_empty();
      for (int i = 0; i < 12; i++) begin
         read_check(addrs[i], cycles);
      end
      // Same index, different tags
      for (int t = 0; t < 4; t++) begin
         write_word(make_addr(t, 6, 2), $random(seed), '1);
      end
      for (int t = 0; t < 4; t++) begin
         read_check(make_addr(t, 6, 2), cycles);
      end
      for (int t = 3; t >= 0; t--) begin
         read_check(make_addr(t, 6, 2), cycles);
      end
   endtask

   initial begin
      seed     = 32'h813e_debe;
      rst      = 1'b1;
      req      = 1'b0;
      req_data = '0;
      for (int i = 0; i < 2**ADDR_W; i++) begin
         ref_mem[i] = '0;
      end
      repeat (8) @(negedge clk);
      rst = 1'b0;
      test_reset();
      test_write_read();
      test_hit_reuse();
      test_byte_strobes();
      test_backpressure();
      $display("TEST PASS");
      $finish;
   end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+testbench
design/cache_pkg.sv
design/cache_store.sv
design/cache_ctrl.sv
design/write_through_buffer.sv
design/line_fill.sv
design/be_arbiter.sv
design/backing_ram.sv
design/cache_top.sv
testbench/cache_tb.sv
